//--- common/event_unit_pkg.sv
// shared constants, types and command/status structs of the cluster event unit
// every design file imports this package in its module header
package event_unit_pkg;

  // cluster size and event counts
  localparam int NB_CORES   = 4;
  localparam int NB_SW_EVT  = 4;
  localparam int NB_EXT_EVT = 3;
  localparam int EVT_W      = 8;

  // bit map of a per-core event vector
  // software events sit at the bottom, then the barrier, then the external lines
  localparam int EVT_SW_LSB   = 0;
  localparam int EVT_BARR_BIT = 4;
  localparam int EVT_EXT_LSB  = 5;

  localparam int SW_ID_W  = 2;
  localparam int IRQ_ID_W = 3;

  typedef logic [NB_CORES-1:0]   core_mask_t;
  typedef logic [EVT_W-1:0]      evt_vec_t;
  typedef logic [SW_ID_W-1:0]    sw_evt_id_t;
  typedef logic [NB_EXT_EVT-1:0] ext_evt_t;
  typedef logic [IRQ_ID_W-1:0]   irq_id_t;

  // commands issued by one core in a single cycle
  // mask_data is shared by both mask writes and by the buffer clear
  typedef struct packed {
    logic       sw_trig;
    sw_evt_id_t sw_id;
    core_mask_t sw_target;
    logic       barr_arrive;
    logic       wait_mask_we;
    logic       irq_mask_we;
    evt_vec_t   mask_data;
    logic       buf_clr;
    logic       wait_req;
  } core_cmd_t;

  // what one core observes from the event unit
  typedef struct packed {
    logic     clock_en;
    logic     irq_req;
    irq_id_t  irq_id;
    evt_vec_t evt_buffer;
  } core_status_t;

  // sleep state of a core
  typedef enum logic {
    CORE_RUN   = 1'b0,
    CORE_SLEEP = 1'b1
  } core_state_e;

endpackage

//--- event_unit.f
common/event_unit_pkg.sv
hdl/sw_event_trigger.sv
hw_barrier/hw_barrier_unit.sv
event_unit_core/event_unit_core.sv
hdl/event_unit_top.sv
verif/event_unit_assertions.sv
verif/event_unit_checker.sv
verif/event_unit_tb.sv

//--- event_unit_core/event_unit_core.sv
// per-core event block: event buffer, wait and irq masks, sleep FSM
// drives the core clock enable and the interrupt request with the lowest pending id
`timescale 1ns/1ps

module event_unit_core
  import event_unit_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  core_cmd_t    cmd_i,
  input  evt_vec_t     events_i,
  input  logic         irq_ack_i,
  output core_status_t status_o
);

  evt_vec_t    evt_buf_q;
  evt_vec_t    evt_buf_nxt;
  evt_vec_t    wait_mask_q;
  evt_vec_t    irq_mask_q;
  core_state_e state_q;
  core_state_e state_nxt;

  evt_vec_t clr_bits;
  evt_vec_t ack_bits;
  evt_vec_t irq_pending;
  logic     wait_hit;
  logic     irq_req;
  irq_id_t  irq_id;

  // masks are written by the core through the shared mask_data field
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wait_mask_q <= '0;
      irq_mask_q  <= '0;
    end else begin
      if (cmd_i.wait_mask_we) begin
        wait_mask_q <= cmd_i.mask_data;
      end
      if (cmd_i.irq_mask_we) begin
        irq_mask_q <= cmd_i.mask_data;
      end
    end
  end

  // bits removed from the buffer at the next edge
  assign clr_bits = cmd_i.buf_clr ? cmd_i.mask_data : '0;

  always_comb begin
    ack_bits = '0;
    if (irq_ack_i && irq_req) begin
      ack_bits[irq_id] = 1'b1;
    end
  end

  // an event arriving on the clearing edge is ORed in last, so it survives
  assign evt_buf_nxt = (evt_buf_q & ~clr_bits & ~ack_bits) | events_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      evt_buf_q <= '0;
    end else begin
      evt_buf_q <= evt_buf_nxt;
    end
  end

  // a waited event is already in the buffer
  assign wait_hit = (evt_buf_q & wait_mask_q) != '0;

  always_comb begin
    state_nxt = state_q;
    case (state_q)
      CORE_RUN: begin
        // a wait with a matching event pending returns at once
        if (cmd_i.wait_req && !wait_hit) begin
          state_nxt = CORE_SLEEP;
        end
      end
      CORE_SLEEP: begin
        if (wait_hit) begin
          state_nxt = CORE_RUN;
        end
      end
      default: begin
        state_nxt = CORE_RUN;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= CORE_RUN;
    end else begin
      state_q <= state_nxt;
    end
  end

  assign irq_pending = evt_buf_q & irq_mask_q;
  assign irq_req     = irq_pending != '0;

  // priority encoder, the lowest pending bit wins
  always_comb begin
    irq_id = '0;
    for (int i = EVT_W - 1; i >= 0; i--) begin
      if (irq_pending[i]) begin
        irq_id = irq_id_t'(i);
      end
    end
  end

  assign status_o.clock_en   = (state_q == CORE_RUN);
  assign status_o.irq_req    = irq_req;
  assign status_o.irq_id     = irq_id;
  assign status_o.evt_buffer = evt_buf_q;

endmodule

//--- hdl/event_unit_top.sv
// cluster event unit for four cores: software triggers, one barrier, external lines
// core commands come in as plain structs, status goes out per core
`timescale 1ns/1ps

module event_unit_top
  import event_unit_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  core_cmd_t    [NB_CORES-1:0] core_cmd_i,
  input  ext_evt_t     [NB_CORES-1:0] ext_evt_i,
  input  core_mask_t                  irq_ack_i,
  input  logic                        barr_cfg_we_i,
  input  core_mask_t                  barr_cfg_mask_i,
  output core_status_t [NB_CORES-1:0] core_status_o
);

  logic [NB_CORES-1:0][NB_SW_EVT-1:0] sw_events;
  core_mask_t                         barr_arrive;
  core_mask_t                         barr_event;
  core_mask_t                         barr_arrived;
  evt_vec_t [NB_CORES-1:0]            core_events;

  sw_event_trigger u_sw_event_trigger (
    .clk_i       ( clk_i      ),
    .rst_n_i     ( rst_n_i    ),
    .core_cmd_i  ( core_cmd_i ),
    .sw_events_o ( sw_events  )
  );

  hw_barrier_unit u_hw_barrier_unit (
    .clk_i           ( clk_i           ),
    .rst_n_i         ( rst_n_i         ),
    .cfg_we_i        ( barr_cfg_we_i   ),
    .cfg_mask_i      ( barr_cfg_mask_i ),
    .arrive_i        ( barr_arrive     ),
    .barrier_event_o ( barr_event      ),
    .arrived_o       ( barr_arrived    )
  );

  for (genvar c = 0; c < NB_CORES; c++) begin : g_core
    // collect the arrival strobes into one mask for the barrier
    assign barr_arrive[c] = core_cmd_i[c].barr_arrive;

    // event vector of this core in the package bit map
    assign core_events[c][EVT_SW_LSB +: NB_SW_EVT]   = sw_events[c];
    assign core_events[c][EVT_BARR_BIT]              = barr_event[c];
    assign core_events[c][EVT_EXT_LSB +: NB_EXT_EVT] = ext_evt_i[c];

    event_unit_core u_event_unit_core (
      .clk_i     ( clk_i            ),
      .rst_n_i   ( rst_n_i          ),
      .cmd_i     ( core_cmd_i[c]    ),
      .events_i  ( core_events[c]   ),
      .irq_ack_i ( irq_ack_i[c]     ),
      .status_o  ( core_status_o[c] )
    );
  end

endmodule

//--- hdl/sw_event_trigger.sv
// software event trigger: fans core trigger commands out to target cores
// produces one-cycle event pulses, one bit per software event id and core
`timescale 1ns/1ps

module sw_event_trigger
  import event_unit_pkg::*;
(
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  core_cmd_t [NB_CORES-1:0]           core_cmd_i,
  output logic [NB_CORES-1:0][NB_SW_EVT-1:0] sw_events_o
);

  // one-hot decoded event id per source core, zero when the core does not trigger
  logic [NB_CORES-1:0][NB_SW_EVT-1:0] src_onehot;

  // events collected for every destination core in this cycle
  logic [NB_CORES-1:0][NB_SW_EVT-1:0] sw_events_d;
  logic [NB_CORES-1:0][NB_SW_EVT-1:0] sw_events_q;

  always_comb begin
    for (int src = 0; src < NB_CORES; src++) begin
      src_onehot[src] = '0;
      if (core_cmd_i[src].sw_trig) begin
        src_onehot[src][core_cmd_i[src].sw_id] = 1'b1;
      end
    end
  end

  // spread each source over its target mask
  // triggers from several cores hitting the same destination simply OR together
  always_comb begin
    sw_events_d = '0;
    for (int src = 0; src < NB_CORES; src++) begin
      for (int dst = 0; dst < NB_CORES; dst++) begin
        if (core_cmd_i[src].sw_target[dst]) begin
          sw_events_d[dst] = sw_events_d[dst] | src_onehot[src];
        end
      end
    end
  end

  // triggers are strobes, so the registered copy is a single cycle pulse
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sw_events_q <= '0;
    end else begin
      sw_events_q <= sw_events_d;
    end
  end

  assign sw_events_o = sw_events_q;

endmodule

//--- hw_barrier/hw_barrier_unit.sv
// hardware barrier with a programmable participant mask
// pulses the barrier event on all participants once the last one has arrived
`timescale 1ns/1ps

module hw_barrier_unit
  import event_unit_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       cfg_we_i,
  input  core_mask_t cfg_mask_i,
  input  core_mask_t arrive_i,
  output core_mask_t barrier_event_o,
  output core_mask_t arrived_o
);

  // programmed participants
  core_mask_t part_mask_q;

  // cores that already arrived in the current round
  core_mask_t status_q;

  core_mask_t event_q;

  core_mask_t arrive_masked;
  core_mask_t status_nxt;
  logic       complete;

  // arrivals from cores outside the participant set never count
  assign arrive_masked = arrive_i & part_mask_q;
  assign status_nxt    = status_q | arrive_masked;

  // an empty participant mask must never complete, otherwise the event
  // would fire on every cycle with nobody waiting for it
  assign complete = (part_mask_q != '0) && ((status_nxt & part_mask_q) == part_mask_q);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      part_mask_q <= '0;
    end else if (cfg_we_i) begin
      part_mask_q <= cfg_mask_i;
    end
  end

  // arrival status and the completion pulse
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      status_q <= '0;
      event_q  <= '0;
    end else if (cfg_we_i) begin
      // reprogramming starts a fresh round
      status_q <= '0;
      event_q  <= '0;
    end else if (complete) begin
      status_q <= '0;
      event_q  <= part_mask_q;
    end else begin
      status_q <= status_nxt;
      event_q  <= '0;
    end
  end

  assign barrier_event_o = event_q;

  // only observed by the bound checks
  assign arrived_o = status_q;

endmodule

//--- verif/event_unit_assertions.sv
// concurrent checks on the event unit top level, attached to every instance by bind
// barrier pulse width and arrival status, interrupt consistency and the sleep clock gate
`timescale 1ns/1ps

module event_unit_assertions
  import event_unit_pkg::*;
(
  input logic                        clk_i,
  input logic                        rst_n_i,
  input logic                        barr_cfg_we_i,
  input core_mask_t                  barr_event_i,
  input core_mask_t                  barr_arrived_i,
  input core_mask_t                  core_sleep_i,
  input core_status_t [NB_CORES-1:0] core_status_i
);

  int fail_count = 0;

  barr_single_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    barr_event_i != '0 |=> barr_event_i == '0)
    else begin
      fail_count++;
      $error("barrier event held for more than one cycle");
    end

  // arrival bits stay set until the round completes or the barrier is reprogrammed
  barr_status_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !barr_cfg_we_i |=> barr_event_i != '0 ||
      (barr_arrived_i & $past(barr_arrived_i)) == $past(barr_arrived_i))
    else begin
      fail_count++;
      $error("barrier arrival status lost a core without a completion");
    end

  for (genvar c = 0; c < NB_CORES; c++) begin : g_core_chk
    irq_needs_event: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      core_status_i[c].irq_req |-> core_status_i[c].evt_buffer != '0)
      else begin
        fail_count++;
        $error("core %0d requests an interrupt with an empty buffer", c);
      end

    sleep_gates_clock: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      core_sleep_i[c] |-> !core_status_i[c].clock_en)
      else begin
        fail_count++;
        $error("core %0d sleeps with its clock enabled", c);
      end
  end

endmodule

bind event_unit_top event_unit_assertions u_event_unit_assertions (
  .clk_i          ( clk_i         ),
  .rst_n_i        ( rst_n_i       ),
  .barr_cfg_we_i  ( barr_cfg_we_i ),
  .barr_event_i   ( barr_event    ),
  .barr_arrived_i ( barr_arrived  ),
  .core_sleep_i   ( {g_core[3].u_event_unit_core.state_q,
                     g_core[2].u_event_unit_core.state_q,
                     g_core[1].u_event_unit_core.state_q,
                     g_core[0].u_event_unit_core.state_q} ),
  .core_status_i  ( core_status_o )
);

//--- verif/event_unit_checker.sv
// compares the status of one core with the expected values from the testbench
// samples at the falling edge, where the registered status is stable
`timescale 1ns/1ps

module event_unit_checker
  import event_unit_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        exp_valid_i,
  input  logic [1:0]                  exp_core_i,
  input  core_status_t                exp_status_i,
  input  core_status_t [NB_CORES-1:0] status_i,
  output int                          mismatch_count_o,
  output int                          check_count_o
);

  int mismatch_count = 0;
  int check_count    = 0;

  task automatic compare_field(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
    if (expected !== actual) begin
      $display("MISMATCH at %0t: core_status_o[%0d].%s expected 0x%0h actual 0x%0h",
               $time, exp_core_i, name, expected, actual);
      mismatch_count++;
    end
  endtask

  always @(negedge clk_i) begin
    core_status_t actual;
    if (exp_valid_i) begin
      actual = status_i[exp_core_i];
      compare_field("clock_en", 8'(exp_status_i.clock_en), 8'(actual.clock_en));
      compare_field("irq_req", 8'(exp_status_i.irq_req), 8'(actual.irq_req));
      // the id only means something while a request is pending
      if (exp_status_i.irq_req) begin
        compare_field("irq_id", 8'(exp_status_i.irq_id), 8'(actual.irq_id));
      end
      compare_field("evt_buffer", exp_status_i.evt_buffer, actual.evt_buffer);
      check_count++;
    end
  end

  assign mismatch_count_o = mismatch_count;
  assign check_count_o    = check_count;

endmodule

//--- verif/event_unit_tb.sv
// testbench for the cluster event unit, replays the test data file one line per cycle
// stimulus lines drive the DUT, expect lines are handed to the checker
`timescale 1ns/1ps

module event_unit_tb
  import event_unit_pkg::*;
();

  localparam int RESET_CYCLES = 4;
  localparam int MAX_CYCLES   = 200;
  localparam int DRAIN_CYCLES = 10;

  localparam int REC_NONE = 0;
  localparam int REC_STIM = 1;
  localparam int REC_EXP  = 2;
  localparam int REC_END  = 3;

  logic                        clk;
  logic                        rst_n;
  core_cmd_t    [NB_CORES-1:0] core_cmd;
  ext_evt_t     [NB_CORES-1:0] ext_evt;
  core_mask_t                  irq_ack;
  logic                        barr_cfg_we;
  core_mask_t                  barr_cfg_mask;
  core_status_t [NB_CORES-1:0] core_status;

  logic         exp_valid;
  logic [1:0]   exp_core;
  core_status_t exp_status;
  int           mismatch_count;
  int           check_count;
  int           expect_count;
  int           other_errors;
  int           fd;

  event_unit_top uut (
    .clk_i           ( clk           ),
    .rst_n_i         ( rst_n         ),
    .core_cmd_i      ( core_cmd      ),
    .ext_evt_i       ( ext_evt       ),
    .irq_ack_i       ( irq_ack       ),
    .barr_cfg_we_i   ( barr_cfg_we   ),
    .barr_cfg_mask_i ( barr_cfg_mask ),
    .core_status_o   ( core_status   )
  );

  event_unit_checker u_checker (
    .clk_i            ( clk            ),
    .exp_valid_i      ( exp_valid      ),
    .exp_core_i       ( exp_core       ),
    .exp_status_i     ( exp_status     ),
    .status_i         ( core_status    ),
    .mismatch_count_o ( mismatch_count ),
    .check_count_o    ( check_count    )
  );

  always #10 clk = ~clk;

  task automatic drive_idle();
    core_cmd      = '0;
    ext_evt       = '0;
    irq_ack       = '0;
    barr_cfg_we   = 1'b0;
    barr_cfg_mask = '0;
    exp_valid     = 1'b0;
  endtask

  // finds the next record, comment lines start with a hash and are skipped
  task automatic read_record(output int kind);
    string tok;
    string rest;
    int    code;
    kind = REC_NONE;
    while (kind == REC_NONE) begin
      code = $fscanf(fd, "%s", tok);
      if (code != 1) begin
        kind = REC_END;
      end else if (tok == "S") begin
        kind = REC_STIM;
      end else if (tok == "E") begin
        kind = REC_EXP;
      end else begin
        if (tok.getc(0) != "#") begin
          $display("ERROR: unknown record type %s in the test data", tok);
          other_errors++;
        end
        code = $fgets(rest, fd);
      end
    end
  endtask

  // barrier arrivals come as a mask, the other command fields belong to one core
  task automatic apply_stimulus();
    logic [3:0]  arrive;
    logic [11:0] ext;
    logic [3:0]  ack;
    logic        cfg_we;
    logic [3:0]  cfg_mask;
    int          core;
    logic        trig;
    logic [1:0]  id;
    logic [3:0]  target;
    logic        wmask_we;
    logic        imask_we;
    logic [7:0]  mask;
    logic        clr;
    logic        wait_req;
    int          code;
    code = $fscanf(fd, " %h %h %h %h %h %h %h %h %h %h %h %h %h %h", arrive, ext, ack,
                   cfg_we, cfg_mask, core, trig, id, target, wmask_we, imask_we, mask,
                   clr, wait_req);
    drive_idle();
    if (code != 14 || core >= NB_CORES) begin
      $display("ERROR: malformed stimulus line in the test data");
      other_errors++;
    end else begin
      for (int c = 0; c < NB_CORES; c++) begin
        core_cmd[c].barr_arrive = arrive[c];
      end
      core_cmd[core].sw_trig      = trig;
      core_cmd[core].sw_id        = id;
      core_cmd[core].sw_target    = target;
      core_cmd[core].wait_mask_we = wmask_we;
      core_cmd[core].irq_mask_we  = imask_we;
      core_cmd[core].mask_data    = mask;
      core_cmd[core].buf_clr      = clr;
      core_cmd[core].wait_req     = wait_req;
      ext_evt       = ext;
      irq_ack       = ack;
      barr_cfg_we   = cfg_we;
      barr_cfg_mask = cfg_mask;
    end
  endtask

  task automatic load_expect();
    int         core;
    logic       clk_en;
    logic       irq_req;
    logic [2:0] irq_id;
    logic [7:0] evt_buf;
    int         code;
    code = $fscanf(fd, " %h %h %h %h %h", core, clk_en, irq_req, irq_id, evt_buf);
    drive_idle();
    if (code != 5 || core >= NB_CORES) begin
      $display("ERROR: malformed expect line in the test data");
      other_errors++;
    end else begin
      exp_core              = core;
      exp_status.clock_en   = clk_en;
      exp_status.irq_req    = irq_req;
      exp_status.irq_id     = irq_id;
      exp_status.evt_buffer = evt_buf;
      exp_valid             = 1'b1;
      expect_count++;
    end
  endtask

  initial begin
    int kind;
    int cycles;
    int wait_cycles;
    int assert_fails;
    clk          = 1'b0;
    rst_n        = 1'b0;
    exp_core     = '0;
    exp_status   = '0;
    expect_count = 0;
    other_errors = 0;
    drive_idle();
    fd = $fopen("verif/event_unit_testdata.txt", "r");
    if (fd == 0) begin
      $display("ERROR: cannot open the test data file verif/event_unit_testdata.txt");
      other_errors++;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;

    kind   = REC_NONE;
    cycles = 0;
    while (fd != 0 && kind != REC_END && cycles < MAX_CYCLES) begin
      read_record(kind);
      if (kind == REC_STIM) begin
        apply_stimulus();
      end else if (kind == REC_EXP) begin
        load_expect();
      end else begin
        drive_idle();
      end
      @(posedge clk);
      #2;
      cycles++;
    end
    if (fd != 0 && kind != REC_END) begin
      $display("ERROR: end of the test data not reached within %0d cycles", MAX_CYCLES);
      other_errors++;
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    drive_idle();

    wait_cycles = 0;
    while (check_count < expect_count && wait_cycles < DRAIN_CYCLES) begin
      @(posedge clk);
      wait_cycles++;
    end
    if (check_count < expect_count) begin
      $display("ERROR: checker finished only %0d of %0d checks", check_count, expect_count);
      other_errors++;
    end
    if (expect_count == 0) begin
      $display("ERROR: no expected values were found in the test data");
      other_errors++;
    end

    assert_fails = uut.u_event_unit_assertions.fail_count;
    $display("summary: %0d checks, %0d mismatches, %0d assertion failures, %0d other errors",
             check_count, mismatch_count, assert_fails, other_errors);
    if (mismatch_count == 0 && assert_fails == 0 && other_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- verif/event_unit_testdata.txt
# S arrive ext(core3..core0) ack cfg_we cfg_mask core trig id target wmask_we imask_we mask clr wait
# E core clock_en irq_req irq_id evt_buffer, all hex, checked in the cycle of the line
S 0 000 0 0 0 0 1 2 a 0 0 00 0 0
E 1 1 0 0 00
E 1 1 0 0 04
E 3 1 0 0 04
E 0 1 0 0 00
E 2 1 0 0 00
S 0 000 0 1 7 0 0 0 0 0 0 00 0 0
S 1 000 0 0 0 0 0 0 0 0 0 00 0 0
S 8 000 0 0 0 0 0 0 0 0 0 00 0 0
S 2 000 0 0 0 0 0 0 0 0 0 00 0 0
E 0 1 0 0 00
S 4 000 0 0 0 0 0 0 0 0 0 00 0 0
E 0 1 0 0 00
E 0 1 0 0 10
E 1 1 0 0 14
E 2 1 0 0 10
E 3 1 0 0 04
S 0 000 0 0 0 2 0 0 0 1 0 20 0 0
S 0 000 0 0 0 2 0 0 0 0 0 00 0 1
E 2 0 0 0 10
S 0 040 0 0 0 0 0 0 0 0 0 00 0 0
E 2 0 0 0 30
E 2 1 0 0 30
S 0 000 0 0 0 2 0 0 0 0 0 00 0 1
E 2 1 0 0 30
S 0 020 0 0 0 1 0 0 0 0 1 f4 0 0
E 1 1 1 2 94
S 0 000 2 0 0 0 0 0 0 0 0 00 0 0
E 1 1 1 4 90
S 0 000 2 0 0 0 0 0 0 0 0 00 0 0
E 1 1 1 7 80
S 0 000 2 0 0 0 0 0 0 0 0 00 0 0
E 1 1 0 0 00
S 0 000 0 0 0 2 0 0 0 0 0 10 1 0
E 2 1 0 0 20
S 0 200 0 0 0 3 0 0 0 0 0 24 1 0
E 3 1 0 0 20
E 0 1 0 0 10
